//--- src.f
logic/udp_cmd_pkg.sv
logic/word_fifo.sv
logic/udp_cmd_parser.sv
logic/axi_wr_master.sv
logic/axi_rd_master.sv
logic/axi_ram.sv
logic/udp_axi_bridge_top.sv
verif/udp_axi_bridge_sva.sv
verif/udp_axi_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module udp_axi_bridge_tb -f src.f -o udp_axi_bridge_sim

./obj_dir/udp_axi_bridge_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

//--- verif/udp_axi_bridge_tb.sv
module udp_axi_bridge_tb
  import udp_cmd_pkg::*;
();

  localparam int MEM_WORDS = 1024;
  localparam int TIMEOUT   = 2000;

  logic      gmii_rx_clk;
  logic      rstn;
  logic      rec_en;
  logic      rec_pkt_done;
  word_t     udp_rx_data;
  logic      tx_req;
  logic      tx_start_en;
  word_t     udp_tx_data;
  logic      cmd_done;
  drop_cnt_t drop_cnt;

  word_t  ref_mem [MEM_WORDS];
  word_t  pkt_q [$];
  int     exp_q [$];
  int     rec_addr [$];
  int     rec_len [$];
  int     start_cnt = 0;
  int     done_cnt = 0;
  int     exp_drops = 0;
  logic   req_pend = 1'b0;
  string  test_name;
  integer seed;

  udp_axi_bridge_top #(
    .MEM_ADDR_BITS (10),
    .FIFO_ADDR_BITS(8)
  ) udp_axi_bridge_top_inst (
    .gmii_rx_clk (gmii_rx_clk),
    .rstn        (rstn),
    .rec_en      (rec_en),
    .rec_pkt_done(rec_pkt_done),
    .udp_rx_data (udp_rx_data),
    .tx_req      (tx_req),
    .tx_start_en (tx_start_en),
    .udp_tx_data (udp_tx_data),
    .cmd_done    (cmd_done),
    .drop_cnt    (drop_cnt)
  );

  initial gmii_rx_clk = 1'b0;
  always #10 gmii_rx_clk = ~gmii_rx_clk;

  // Expected word at an address, wrapped to the memory depth
  function automatic word_t exp_word(input int addr);
    return ref_mem[addr % MEM_WORDS];
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("CHECK FAILED %s: expected 0x%08h, actual 0x%08h",
                          name, expected, actual));
    end
  endtask

  // Pulse counters, sampled mid-cycle
  always @(negedge gmii_rx_clk) begin
    if (tx_start_en) begin
      start_cnt++;
    end
    if (cmd_done) begin
      done_cnt++;
    end
  end

  // Word requested on the previous cycle is on udp_tx_data now
  always @(negedge gmii_rx_clk) begin
    if (rstn && req_pend) begin
      check_val(test_name, exp_word(exp_q.pop_front()), udp_tx_data);
    end
    req_pend = tx_req;
  end

  task automatic wait_start(input int target);
    int cycles;
    cycles = 0;
    while (start_cnt < target) begin
      @(posedge gmii_rx_clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout: tx_start_en never pulsed for the read command");
      end
    end
  endtask

  task automatic wait_done(input int target);
    int cycles;
    cycles = 0;
    while (done_cnt < target) begin
      @(posedge gmii_rx_clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout: cmd_done never pulsed for the command");
      end
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() > 0) begin
      @(posedge gmii_rx_clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("Timeout: requested read words never came back");
      end
    end
  endtask

  task automatic send_packet();
    word_t w;
    while (pkt_q.size() > 0) begin
      w = pkt_q.pop_front();
      @(posedge gmii_rx_clk);
      rec_en      <= 1'b1;
      udp_rx_data <= w;
    end
    @(posedge gmii_rx_clk);
    rec_en       <= 1'b0;
    rec_pkt_done <= 1'b1;
    @(posedge gmii_rx_clk);
    rec_pkt_done <= 1'b0;
  endtask

  // A dropped write leaves the reference untouched
  task automatic send_write(input int addr, input int len, input bit dropped);
    int    target;
    int    i;
    word_t w;
    target = done_cnt + 1;
    pkt_q.push_back({1'b1, 23'd0, 8'(len)});
    pkt_q.push_back({4'd0, 28'(addr)});
    for (i = 0; i <= len; i++) begin
      w = $random(seed);
      pkt_q.push_back(w);
      if (!dropped) begin
        ref_mem[(addr + i) % MEM_WORDS] = w;
      end
    end
    send_packet();
    if (!dropped) begin
      wait_done(target);
      rec_addr.push_back(addr);
      rec_len.push_back(len);
    end else begin
      exp_drops++;
    end
  endtask

  task automatic send_read_pkt(input int addr, input int len);
    pkt_q.push_back({1'b0, 23'd0, 8'(len)});
    pkt_q.push_back({4'd0, 28'(addr)});
    send_packet();
  endtask

  task automatic fetch_read(input int addr, input int len, input int s_target,
                            input int d_target);
    int i;
    wait_start(s_target);
    for (i = 0; i <= len; i++) begin
      @(posedge gmii_rx_clk);
      tx_req <= 1'b1;
      exp_q.push_back(addr + i);
    end
    @(posedge gmii_rx_clk);
    tx_req <= 1'b0;
    wait_done(d_target);
    wait_drain();
  endtask

  task automatic read_back(input int addr, input int len);
    int s;
    int d;
    s = start_cnt + 1;
    d = done_cnt + 1;
    send_read_pkt(addr, len);
    fetch_read(addr, len, s, d);
  endtask

  initial begin
    int        n;
    int        k;
    int        a;
    int        idx;
    int        off;
    int        s;
    int        d;
    seed         = 49;
    rstn         = 1'b0;
    rec_en       = 1'b0;
    rec_pkt_done = 1'b0;
    udp_rx_data  = '0;
    tx_req       = 1'b0;
    repeat (5) @(posedge gmii_rx_clk);
    rstn <= 1'b1;

    test_name = "idle_after_reset";
    @(posedge gmii_rx_clk);
    check_val(test_name, 0, 32'(drop_cnt));
    repeat (50) @(posedge gmii_rx_clk);
    check_val(test_name, 0, start_cnt);
    check_val(test_name, 0, done_cnt);

    test_name = "write_read_8";
    send_write(16, 7, 1'b0);
    read_back(16, 7);

    test_name = "single_last_addr";
    send_write(MEM_WORDS - 1, 0, 1'b0);
    read_back(MEM_WORDS - 1, 0);

    test_name = "full_burst";
    send_write(256, 255, 1'b0);
    read_back(256, 255);

    // Reads only cover ranges that some write has filled
    test_name = "random_cmds";
    for (n = 0; n < 20; n++) begin
      if (($random(seed) & 1) == 1) begin
        k = $unsigned($random(seed)) % 256;
        a = $unsigned($random(seed)) % (MEM_WORDS - k);
        send_write(a, k, 1'b0);
      end else begin
        idx = $unsigned($random(seed)) % rec_addr.size();
        off = $unsigned($random(seed)) % (rec_len[idx] + 1);
        k   = $unsigned($random(seed)) % (rec_len[idx] + 1 - off);
        read_back(rec_addr[idx] + off, k);
      end
    end

    test_name = "drop_while_busy";
    s     = start_cnt + 1;
    d     = done_cnt + 1;
    send_read_pkt(256, 255);
    send_write(16, 7, 1'b1);
    check_val(test_name, s - 1, start_cnt);
    fetch_read(256, 255, s, d);
    check_val(test_name, exp_drops, 32'(drop_cnt));
    read_back(16, 7);

    $display("All checks passed");
    $finish;
  end

endmodule

//--- verif/udp_axi_bridge_sva.sv
module udp_axi_bridge_sva (
  input logic gmii_rx_clk,
  input logic rstn,
  input logic wr_addr_valid,
  input logic wr_addr_ready,
  input logic wr_data_valid,
  input logic wr_data_ready,
  input logic rd_addr_valid,
  input logic rd_addr_ready,
  input logic rd_data_valid,
  input logic rd_data_ready,
  input logic tx_start_en,
  input logic cmd_done
);

  // Valid stays up until the slave takes the transfer
  a_wr_addr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    wr_addr_valid && !wr_addr_ready |=> wr_addr_valid)
    else $error("wr_addr_valid dropped before wr_addr_ready");

  a_wr_data_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    wr_data_valid && !wr_data_ready |=> wr_data_valid)
    else $error("wr_data_valid dropped before wr_data_ready");

  a_rd_addr_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    rd_addr_valid && !rd_addr_ready |=> rd_addr_valid)
    else $error("rd_addr_valid dropped before rd_addr_ready");

  a_rd_data_hold: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    rd_data_valid && !rd_data_ready |=> rd_data_valid)
    else $error("rd_data_valid dropped before rd_data_ready");

  a_start_pulse: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    tx_start_en |=> !tx_start_en)
    else $error("tx_start_en high for more than one cycle");

  a_done_pulse: assert property (@(posedge gmii_rx_clk) disable iff (!rstn)
    cmd_done |=> !cmd_done)
    else $error("cmd_done high for more than one cycle");

  a_reset_quiet: assert property (@(posedge gmii_rx_clk)
    !rstn |=> !(tx_start_en || cmd_done || wr_addr_valid || wr_data_valid ||
                rd_addr_valid || rd_data_valid))
    else $error("Pulse or valid output high during reset");

endmodule

bind udp_axi_bridge_top udp_axi_bridge_sva udp_axi_bridge_sva_inst (
  .gmii_rx_clk  (gmii_rx_clk),
  .rstn         (rstn),
  .wr_addr_valid(wr_addr_valid),
  .wr_addr_ready(wr_addr_ready),
  .wr_data_valid(wr_data_valid),
  .wr_data_ready(wr_data_ready),
  .rd_addr_valid(rd_addr_valid),
  .rd_addr_ready(rd_addr_ready),
  .rd_data_valid(rd_data_valid),
  .rd_data_ready(rd_data_ready),
  .tx_start_en  (tx_start_en),
  .cmd_done     (cmd_done)
);

//--- logic/udp_axi_bridge_top.sv
module udp_axi_bridge_top
  import udp_cmd_pkg::*;
#(
  parameter int MEM_ADDR_BITS  = 10,
  parameter int FIFO_ADDR_BITS = 8
) (
  input  logic      gmii_rx_clk,
  input  logic      rstn,
  input  logic      rec_en,
  input  logic      rec_pkt_done,
  input  word_t     udp_rx_data,
  input  logic      tx_req,
  output logic      tx_start_en,
  output word_t     udp_tx_data,
  output logic      cmd_done,
  output drop_cnt_t drop_cnt
);

  logic       busy;
  logic       cmd_go;
  cmd_op_e    cmd_op;
  axi_addr_t  cmd_addr;
  burst_len_t cmd_len;
  logic       pay_push;
  word_t      pay_data;
  logic       pay_pop;
  word_t      pay_fifo_data;
  logic       pay_empty;
  logic       wr_done;
  logic       rd_done;

  axi_addr_t  wr_addr;
  burst_len_t wr_len;
  logic       wr_addr_valid;
  logic       wr_addr_ready;
  word_t      wr_data;
  logic       wr_data_valid;
  logic       wr_data_ready;
  logic       wr_data_last;
  logic       wr_back_valid;
  axi_addr_t  rd_addr;
  burst_len_t rd_len;
  logic       rd_addr_valid;
  logic       rd_addr_ready;
  word_t      rd_data;
  logic       rd_data_valid;
  logic       rd_data_ready;
  logic       rd_data_last;

  // One command in flight, new packets are dropped meanwhile
  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      busy <= 1'b0;
    end else if (cmd_go) begin
      busy <= 1'b1;
    end else if (wr_done || rd_done) begin
      busy <= 1'b0;
    end
  end

  assign cmd_done = wr_done | rd_done;

  udp_cmd_parser udp_cmd_parser_inst (
    .gmii_rx_clk (gmii_rx_clk),
    .rstn        (rstn),
    .rec_en      (rec_en),
    .rec_pkt_done(rec_pkt_done),
    .udp_rx_data (udp_rx_data),
    .busy        (busy),
    .cmd_go      (cmd_go),
    .cmd_op      (cmd_op),
    .cmd_addr    (cmd_addr),
    .cmd_len     (cmd_len),
    .pay_push    (pay_push),
    .pay_data    (pay_data),
    .drop_cnt    (drop_cnt)
  );

  word_fifo #(
    .FIFO_ADDR_BITS(FIFO_ADDR_BITS)
  ) pay_fifo_inst (
    .gmii_rx_clk(gmii_rx_clk),
    .rstn       (rstn),
    .push       (pay_push),
    .push_data  (pay_data),
    .pop        (pay_pop),
    .pop_data   (pay_fifo_data),
    .empty      (pay_empty),
    .full       ()
  );

  axi_wr_master axi_wr_master_inst (
    .gmii_rx_clk  (gmii_rx_clk),
    .rstn         (rstn),
    .cmd_go       (cmd_go),
    .cmd_op       (cmd_op),
    .cmd_addr     (cmd_addr),
    .cmd_len      (cmd_len),
    .pay_pop      (pay_pop),
    .pay_data     (pay_fifo_data),
    .pay_empty    (pay_empty),
    .wr_addr      (wr_addr),
    .wr_len       (wr_len),
    .wr_addr_valid(wr_addr_valid),
    .wr_addr_ready(wr_addr_ready),
    .wr_data      (wr_data),
    .wr_data_valid(wr_data_valid),
    .wr_data_last (wr_data_last),
    .wr_data_ready(wr_data_ready),
    .wr_back_valid(wr_back_valid),
    .wr_done      (wr_done)
  );

  axi_rd_master #(
    .FIFO_ADDR_BITS(FIFO_ADDR_BITS)
  ) axi_rd_master_inst (
    .gmii_rx_clk  (gmii_rx_clk),
    .rstn         (rstn),
    .cmd_go       (cmd_go),
    .cmd_op       (cmd_op),
    .cmd_addr     (cmd_addr),
    .cmd_len      (cmd_len),
    .rd_addr      (rd_addr),
    .rd_len       (rd_len),
    .rd_addr_valid(rd_addr_valid),
    .rd_addr_ready(rd_addr_ready),
    .rd_data      (rd_data),
    .rd_data_valid(rd_data_valid),
    .rd_data_last (rd_data_last),
    .rd_data_ready(rd_data_ready),
    .tx_start_en  (tx_start_en),
    .tx_req       (tx_req),
    .udp_tx_data  (udp_tx_data),
    .rd_done      (rd_done)
  );

  axi_ram #(
    .MEM_ADDR_BITS(MEM_ADDR_BITS)
  ) axi_ram_inst (
    .gmii_rx_clk  (gmii_rx_clk),
    .rstn         (rstn),
    .wr_addr      (wr_addr),
    .wr_len       (wr_len),
    .wr_addr_valid(wr_addr_valid),
    .wr_addr_ready(wr_addr_ready),
    .wr_data      (wr_data),
    .wr_data_valid(wr_data_valid),
    .wr_data_ready(wr_data_ready),
    .wr_data_last (wr_data_last),
    .wr_back_valid(wr_back_valid),
    .rd_addr      (rd_addr),
    .rd_len       (rd_len),
    .rd_addr_valid(rd_addr_valid),
    .rd_addr_ready(rd_addr_ready),
    .rd_data      (rd_data),
    .rd_data_valid(rd_data_valid),
    .rd_data_ready(rd_data_ready),
    .rd_data_last (rd_data_last)
  );

endmodule

//--- logic/axi_ram.sv
module axi_ram
  import udp_cmd_pkg::*;
#(
  parameter int MEM_ADDR_BITS = 10
) (
  input  logic       gmii_rx_clk,
  input  logic       rstn,
  input  axi_addr_t  wr_addr,
  input  burst_len_t wr_len,
  input  logic       wr_addr_valid,
  output logic       wr_addr_ready,
  input  word_t      wr_data,
  input  logic       wr_data_valid,
  output logic       wr_data_ready,
  input  logic       wr_data_last,
  output logic       wr_back_valid,
  input  axi_addr_t  rd_addr,
  input  burst_len_t rd_len,
  input  logic       rd_addr_valid,
  output logic       rd_addr_ready,
  output word_t      rd_data,
  output logic       rd_data_valid,
  input  logic       rd_data_ready,
  output logic       rd_data_last
);

  localparam int MEM_DEPTH = 2 ** MEM_ADDR_BITS;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    RESP,
    READ_WAIT,
    READ
  } state_e;

  word_t                    mem [MEM_DEPTH];
  state_e                   state;
  logic [MEM_ADDR_BITS-1:0] ptr;
  burst_len_t               burst_len;
  burst_len_t               beat_cnt;
  logic                     wr_beat;
  logic                     rd_beat;
  logic                     rd_load;

  assign wr_data_ready = (state == WRITE);
  assign wr_back_valid = (state == RESP);
  assign wr_beat       = wr_data_valid && wr_data_ready;
  assign rd_beat       = rd_data_valid && rd_data_ready;

  // Fetch the first word in READ_WAIT, then the next one on each accepted beat
  assign rd_load = (state == READ_WAIT) || ((state == READ) && rd_beat && !rd_data_last);

  always_ff @(posedge gmii_rx_clk) begin
    if (wr_beat) begin
      mem[ptr] <= wr_data;
    end
    if (rd_load) begin
      rd_data <= mem[ptr];
    end
  end

  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      state         <= IDLE;
      wr_addr_ready <= 1'b0;
      rd_addr_ready <= 1'b0;
      rd_data_valid <= 1'b0;
      rd_data_last  <= 1'b0;
      ptr           <= '0;
      burst_len     <= '0;
      beat_cnt      <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (wr_addr_valid && wr_addr_ready) begin
            wr_addr_ready <= 1'b0;
            ptr           <= wr_addr[MEM_ADDR_BITS-1:0];
            burst_len     <= wr_len;
            beat_cnt      <= '0;
            state         <= WRITE;
          end else if (rd_addr_valid && rd_addr_ready) begin
            rd_addr_ready <= 1'b0;
            ptr           <= rd_addr[MEM_ADDR_BITS-1:0];
            burst_len     <= rd_len;
            beat_cnt      <= '0;
            state         <= READ_WAIT;
          end else if (wr_addr_valid) begin
            wr_addr_ready <= 1'b1;
          end else if (rd_addr_valid) begin
            rd_addr_ready <= 1'b1;
          end
        end
        WRITE: begin
          if (wr_beat) begin
            ptr      <= ptr + 1'b1;
            beat_cnt <= beat_cnt + 1'b1;
            // Either the last flag or the address-channel length ends the burst
            if (wr_data_last || (beat_cnt == burst_len)) begin
              state <= RESP;
            end
          end
        end
        RESP: state <= IDLE;
        READ_WAIT, READ: begin
          if (rd_load) begin
            ptr           <= ptr + 1'b1;
            beat_cnt      <= beat_cnt + 1'b1;
            rd_data_valid <= 1'b1;
            rd_data_last  <= (beat_cnt == burst_len);
            state         <= READ;
          end else if (rd_beat) begin
            rd_data_valid <= 1'b0;
            rd_data_last  <= 1'b0;
            state         <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- logic/axi_rd_master.sv
module axi_rd_master
  import udp_cmd_pkg::*;
#(
  parameter int FIFO_ADDR_BITS = 8
) (
  input  logic       gmii_rx_clk,
  input  logic       rstn,
  input  logic       cmd_go,
  input  cmd_op_e    cmd_op,
  input  axi_addr_t  cmd_addr,
  input  burst_len_t cmd_len,
  output axi_addr_t  rd_addr,
  output burst_len_t rd_len,
  output logic       rd_addr_valid,
  input  logic       rd_addr_ready,
  input  word_t      rd_data,
  input  logic       rd_data_valid,
  input  logic       rd_data_last,
  output logic       rd_data_ready,
  output logic       tx_start_en,
  input  logic       tx_req,
  output word_t      udp_tx_data,
  output logic       rd_done
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    FILL,
    SEND
  } state_e;

  state_e     state;
  burst_len_t req_cnt;
  logic       tx_push;
  logic       tx_pop;
  logic       tx_empty;
  logic       tx_full;
  logic       start;

  assign start         = (state == IDLE) && cmd_go && (cmd_op == CMD_READ);
  assign rd_data_ready = (state == FILL) && !tx_full;
  assign tx_push       = rd_data_valid && rd_data_ready;
  assign tx_pop        = (state == SEND) && tx_req && !tx_empty;

  // Whole burst is buffered before the transmitter is started
  word_fifo #(
    .FIFO_ADDR_BITS(FIFO_ADDR_BITS)
  ) tx_fifo_inst (
    .gmii_rx_clk(gmii_rx_clk),
    .rstn       (rstn),
    .push       (tx_push),
    .push_data  (rd_data),
    .pop        (tx_pop),
    .pop_data   (udp_tx_data),
    .empty      (tx_empty),
    .full       (tx_full)
  );

  always_ff @(posedge gmii_rx_clk) begin
    if (start) begin
      rd_addr <= cmd_addr;
      rd_len  <= cmd_len;
    end
  end

  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      state         <= IDLE;
      rd_addr_valid <= 1'b0;
      tx_start_en   <= 1'b0;
      rd_done       <= 1'b0;
      req_cnt       <= '0;
    end else begin
      tx_start_en <= 1'b0;
      rd_done     <= 1'b0;
      case (state)
        IDLE: begin
          if (start) begin
            rd_addr_valid <= 1'b1;
            state         <= ADDR;
          end
        end
        ADDR: begin
          if (rd_addr_ready) begin
            rd_addr_valid <= 1'b0;
            state         <= FILL;
          end
        end
        FILL: begin
          if (tx_push && rd_data_last) begin
            tx_start_en <= 1'b1;
            req_cnt     <= '0;
            state       <= SEND;
          end
        end
        SEND: begin
          if (tx_req) begin
            req_cnt <= req_cnt + 1'b1;
            if (req_cnt == rd_len) begin
              rd_done <= 1'b1;
              state   <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- logic/axi_wr_master.sv
module axi_wr_master
  import udp_cmd_pkg::*;
(
  input  logic       gmii_rx_clk,
  input  logic       rstn,
  input  logic       cmd_go,
  input  cmd_op_e    cmd_op,
  input  axi_addr_t  cmd_addr,
  input  burst_len_t cmd_len,
  output logic       pay_pop,
  input  word_t      pay_data,
  input  logic       pay_empty,
  output axi_addr_t  wr_addr,
  output burst_len_t wr_len,
  output logic       wr_addr_valid,
  input  logic       wr_addr_ready,
  output word_t      wr_data,
  output logic       wr_data_valid,
  output logic       wr_data_last,
  input  logic       wr_data_ready,
  input  logic       wr_back_valid,
  output logic       wr_done
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA,
    RESP
  } state_e;

  state_e     state;
  burst_len_t beat_cnt;
  logic       from_fifo;
  logic       load;
  logic       start;

  assign start = (state == IDLE) && cmd_go && (cmd_op == CMD_WRITE);

  // Next beat is fetched on the address handshake and on every accepted beat
  assign load = ((state == ADDR) && wr_addr_valid && wr_addr_ready) ||
                ((state == DATA) && wr_data_valid && wr_data_ready && !wr_data_last);
  assign pay_pop = load && !pay_empty;

  // Missing payload goes out as zero
  assign wr_data = from_fifo ? pay_data : '0;

  always_ff @(posedge gmii_rx_clk) begin
    if (start) begin
      wr_addr <= cmd_addr;
      wr_len  <= cmd_len;
    end
  end

  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      state         <= IDLE;
      wr_addr_valid <= 1'b0;
      wr_data_valid <= 1'b0;
      wr_data_last  <= 1'b0;
      beat_cnt      <= '0;
      from_fifo     <= 1'b0;
      wr_done       <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      if (load) begin
        wr_data_valid <= 1'b1;
        from_fifo     <= !pay_empty;
        wr_data_last  <= (beat_cnt == wr_len);
        beat_cnt      <= beat_cnt + 1'b1;
      end
      case (state)
        IDLE: begin
          if (start) begin
            wr_addr_valid <= 1'b1;
            beat_cnt      <= '0;
            state         <= ADDR;
          end
        end
        ADDR: begin
          if (wr_addr_ready) begin
            wr_addr_valid <= 1'b0;
            state         <= DATA;
          end
        end
        DATA: begin
          if (wr_data_valid && wr_data_ready && wr_data_last) begin
            wr_data_valid <= 1'b0;
            wr_data_last  <= 1'b0;
            state         <= RESP;
          end
        end
        RESP: begin
          if (wr_back_valid) begin
            wr_done <= 1'b1;
            state   <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- logic/udp_cmd_parser.sv
module udp_cmd_parser
  import udp_cmd_pkg::*;
(
  input  logic       gmii_rx_clk,
  input  logic       rstn,
  input  logic       rec_en,
  input  logic       rec_pkt_done,
  input  word_t      udp_rx_data,
  input  logic       busy,
  output logic       cmd_go,
  output cmd_op_e    cmd_op,
  output axi_addr_t  cmd_addr,
  output burst_len_t cmd_len,
  output logic       pay_push,
  output word_t      pay_data,
  output drop_cnt_t  drop_cnt
);

  typedef enum logic [1:0] {
    IDLE,
    HDR1,
    PAYLOAD,
    DROP
  } state_e;

  state_e     state;
  logic [8:0] pay_cnt;
  logic       hdr0_take;
  logic       hdr1_take;

  // A command that is about to start counts as busy too
  assign hdr0_take = (state == IDLE) && rec_en && !busy && !cmd_go;
  assign hdr1_take = (state == HDR1) && rec_en;

  // Words past the burst length are dropped here
  assign pay_push = (state == PAYLOAD) && rec_en && (cmd_op == CMD_WRITE) &&
                    (pay_cnt <= {1'b0, cmd_len});
  assign pay_data = udp_rx_data;

  always_ff @(posedge gmii_rx_clk) begin
    if (hdr0_take) begin
      cmd_op  <= cmd_op_e'(udp_rx_data[OP_BIT]);
      cmd_len <= udp_rx_data[LEN_LSB +: $bits(burst_len_t)];
    end
    if (hdr1_take) begin
      cmd_addr <= udp_rx_data[ADDR_LSB +: $bits(axi_addr_t)];
    end
  end

  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      state    <= IDLE;
      pay_cnt  <= '0;
      cmd_go   <= 1'b0;
      drop_cnt <= '0;
    end else begin
      cmd_go <= 1'b0;
      case (state)
        IDLE: begin
          pay_cnt <= '0;
          if (rec_en) begin
            state <= hdr0_take ? HDR1 : DROP;
          end
        end
        HDR1: begin
          // Packet too short to be a command
          if (rec_pkt_done) begin
            state <= IDLE;
          end else if (rec_en) begin
            state <= PAYLOAD;
          end
        end
        PAYLOAD: begin
          if (pay_push) begin
            pay_cnt <= pay_cnt + 1'b1;
          end
          if (rec_pkt_done) begin
            cmd_go <= 1'b1;
            state  <= IDLE;
          end
        end
        DROP: begin
          if (rec_pkt_done) begin
            drop_cnt <= drop_cnt + 1'b1;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- logic/word_fifo.sv
module word_fifo
  import udp_cmd_pkg::*;
#(
  parameter int FIFO_ADDR_BITS = 8
) (
  input  logic  gmii_rx_clk,
  input  logic  rstn,
  input  logic  push,
  input  word_t push_data,
  input  logic  pop,
  output word_t pop_data,
  output logic  empty,
  output logic  full
);

  localparam int DEPTH = 2 ** FIFO_ADDR_BITS;

  word_t                   mem [DEPTH];
  logic [FIFO_ADDR_BITS:0] wr_ptr;
  logic [FIFO_ADDR_BITS:0] rd_ptr;
  logic                    do_push;
  logic                    do_pop;

  // Extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
                 (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge gmii_rx_clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Registered read port, output holds until the next pop
  always_ff @(posedge gmii_rx_clk) begin
    if (do_push) begin
      mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= push_data;
    end
    if (do_pop) begin
      pop_data <= mem[rd_ptr[FIFO_ADDR_BITS-1:0]];
    end
  end

endmodule

//--- logic/udp_cmd_pkg.sv
package udp_cmd_pkg;

  // Data word on both the UDP and the AXI side
  typedef logic [31:0] word_t;

  // Word address carried in header word 1
  typedef logic [27:0] axi_addr_t;

  // Burst length minus one, 1 to 256 words
  typedef logic [7:0] burst_len_t;

  // Discarded packet counter
  typedef logic [15:0] drop_cnt_t;

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cmd_op_e;

  // Header word 0 layout
  localparam int OP_BIT  = 31;
  localparam int LEN_LSB = 0;

  // Header word 1 layout
  localparam int ADDR_LSB = 0;

endpackage
